/* sources.f */
verilog/dcache_pkg.sv
verilog/dcache_req_if.sv
verilog/dcache_rsp_if.sv
verilog/dcache_req_decode.sv
verilog/dcache_lru.sv
verilog/dcache_ctrl.sv
verilog/dcache_rsp_align.sv
verilog/data_cache.sv
verification/tb_mem_model.sv
verification/tb_data_cache.sv

/* run_sim.sh */
#!/bin/sh
# Compile the data cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_data_cache \
    -Mdir obj_dir -o sim_data_cache

./obj_dir/sim_data_cache | tee sim.log

if grep -qx "Simulation passed" sim.log; then
    exit 0
else
    exit 1
fi

/* verification/tb_data_cache.sv */
////////////////////////////////////////
// Data cache testbench
// Directed tests for hits, misses,
// faults, eviction and LRU order
////////////////////////////////////////
`timescale 1ns/1ps

module tb_data_cache
    import dcache_pkg::*;
();

    localparam int HALF_PERIOD = 20;
    localparam int WAIT_LIMIT  = 200;

    logic       clock;
    logic       rst_n;
    logic       req_valid;
    addr_t      req_addr;
    logic       req_is_store;
    acc_size_e  req_size;
    word_t      req_wdata;
    logic       ready;
    logic       rsp_valid;
    word_t      rsp_data;
    logic       addr_fault;
    logic       mem_req_valid;
    line_addr_t mem_req_addr;
    logic       mem_req_is_store;
    line_t      mem_req_data;
    logic       mem_rsp_valid;
    line_t      mem_rsp_data;
    int         wb_count;
    line_addr_t wb_addr;
    line_t      wb_line;
    int         overlap_count;

    int errors;
    int checks;

    data_cache data_cache_i (
        .clock            (clock),
        .rst_n            (rst_n),
        .req_valid        (req_valid),
        .req_addr         (req_addr),
        .req_is_store     (req_is_store),
        .req_size         (req_size),
        .req_wdata        (req_wdata),
        .ready            (ready),
        .rsp_valid        (rsp_valid),
        .rsp_data         (rsp_data),
        .addr_fault       (addr_fault),
        .mem_req_valid    (mem_req_valid),
        .mem_req_addr     (mem_req_addr),
        .mem_req_is_store (mem_req_is_store),
        .mem_req_data     (mem_req_data),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp_data     (mem_rsp_data)
    );

    tb_mem_model mem_i (
        .clock            (clock),
        .rst_n            (rst_n),
        .mem_req_valid    (mem_req_valid),
        .mem_req_addr     (mem_req_addr),
        .mem_req_is_store (mem_req_is_store),
        .mem_req_data     (mem_req_data),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp_data     (mem_rsp_data),
        .wb_count         (wb_count),
        .wb_addr          (wb_addr),
        .wb_line          (wb_line),
        .overlap_count    (overlap_count)
    );

    initial
    begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    ////////////////////////////////////////
    // Expected data and checking
    ////////////////////////////////////////

    // Memory content rule, every address byte takes part
    function automatic logic [7:0] expected_byte(addr_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    // Little endian word starting at a
    function automatic word_t expected_word(addr_t a);
        return {expected_byte(a + 32'd3), expected_byte(a + 32'd2),
                expected_byte(a + 32'd1), expected_byte(a)};
    endfunction

    function automatic line_t expected_line(line_addr_t la);
        line_t result;
        for (int b = 0; b < LINE_BYTES; b++)
            result[b*8 +: 8] = expected_byte({la, 4'(b)});
        return result;
    endfunction

    task automatic check_val(input string name, input line_t got, input line_t expv);
        checks++;
        if (got !== expv)
        begin
            errors++;
            $display("ERR %s got %0h expected %0h at %0t", name, got, expv, $time);
        end
    endtask

    task automatic give_up(input string what);
        $display("Timeout while waiting for %s at %0t", what, $time);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    endtask

    ////////////////////////////////////////
    // Request helpers
    ////////////////////////////////////////

    // Called right after a falling edge, returns at the one after acceptance
    task automatic wait_ready(input string what);
        int n;
        n = 0;
        while (!ready)
        begin
            @(negedge clock);
            n++;
            if (n > WAIT_LIMIT)
                give_up(what);
        end
    endtask

    task automatic send_req(input addr_t a, input logic st, input acc_size_e sz,
                            input word_t wd);
        req_valid    = 1'b1;
        req_addr     = a;
        req_is_store = st;
        req_size     = sz;
        req_wdata    = wd;
        wait_ready("request acceptance");
        @(posedge clock);
        @(negedge clock);
        req_valid = 1'b0;
    endtask

    // Acceptance edge counts as the first edge
    task automatic wait_response(output int edges, output logic faulted);
        edges = 1;
        while (!rsp_valid && !addr_fault)
        begin
            @(negedge clock);
            edges++;
            if (edges > WAIT_LIMIT)
                give_up("load response or fault");
        end
        faulted = addr_fault;
    endtask

    // exp_edges of 0 means a miss with open latency
    task automatic load_check(input addr_t a, input acc_size_e sz, input word_t expv,
                              input int exp_edges);
        int   edges;
        logic faulted;
        send_req(a, 1'b0, sz, '0);
        wait_response(edges, faulted);
        check_val("addr_fault", line_t'(faulted), line_t'(0));
        check_val("rsp_data", line_t'(rsp_data), line_t'(expv));
        // Ready is back by the time the data shows up
        check_val("ready", line_t'(ready), line_t'(1));
        if (exp_edges != 0)
            check_val("rsp_valid latency", line_t'(edges), line_t'(exp_edges));
        @(negedge clock);
        check_val("rsp_valid", line_t'(rsp_valid), line_t'(0));
    endtask

    task automatic store_req(input addr_t a, input acc_size_e sz, input word_t wd);
        send_req(a, 1'b1, sz, wd);
        wait_ready("store completion");
    endtask

    task automatic fault_check(input addr_t a, input logic st);
        int   edges;
        logic faulted;
        send_req(a, st, size_word, 32'hffff_ffff);
        wait_response(edges, faulted);
        check_val("addr_fault", line_t'(faulted), line_t'(1));
        check_val("rsp_valid", line_t'(rsp_valid), line_t'(0));
        check_val("addr_fault latency", line_t'(edges), line_t'(2));
        @(negedge clock);
        check_val("addr_fault", line_t'(addr_fault), line_t'(0));
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic load_miss_then_hit();
        load_check(32'h013, size_byte, {24'h0, expected_byte(32'h013)}, 0);
        load_check(32'h024, size_word, expected_word(32'h024), 0);
        // Same lines again, all hits
        load_check(32'h018, size_word, expected_word(32'h018), 2);
        load_check(32'h013, size_byte, {24'h0, expected_byte(32'h013)}, 2);
        load_check(32'h024, size_word, expected_word(32'h024), 2);
    endtask

    task automatic store_hit_readback();
        store_req(32'h011, size_byte, 32'h0000_00a7);
        store_req(32'h01c, size_word, 32'hdead_beef);
        load_check(32'h011, size_byte, 32'h0000_00a7, 2);
        load_check(32'h01c, size_word, 32'hdead_beef, 2);
        // Neighbours untouched
        load_check(32'h010, size_byte, {24'h0, expected_byte(32'h010)}, 2);
        load_check(32'h012, size_byte, {24'h0, expected_byte(32'h012)}, 2);
        load_check(32'h018, size_word, expected_word(32'h018), 2);
    endtask

    task automatic fault_access();
        fault_check(32'h032, 1'b0);
        fault_check(32'h026, 1'b1);
        // Misaligned store left the line alone
        load_check(32'h024, size_word, expected_word(32'h024), 2);
        load_check(32'h026, size_byte, {24'h0, expected_byte(32'h026)}, 2);
    endtask

    task automatic evict_and_lru();
        int    wb_before;
        line_t wb_exp;
        // Tags 0 and 1 of set 0, both dirty
        store_req(32'h004, size_word, 32'h1111_1111);
        store_req(32'h048, size_byte, 32'h0000_0022);
        // Tag 0 becomes youngest, tag 1 is the victim
        load_check(32'h004, size_word, 32'h1111_1111, 2);
        wb_before = wb_count;
        load_check(32'h08c, size_word, expected_word(32'h08c), 0);
        wb_exp          = expected_line(28'h4);
        wb_exp[64 +: 8] = 8'h22;
        check_val("wb_count", line_t'(wb_count - wb_before), line_t'(1));
        check_val("wb_addr", line_t'(wb_addr), line_t'(28'h4));
        check_val("wb_line", wb_line, wb_exp);
        // Stored byte comes back through memory
        load_check(32'h048, size_byte, 32'h0000_0022, 0);
    endtask

    task automatic back_to_back_hits();
        addr_t     addrs [8];
        acc_size_e sizes [8];
        word_t     exps  [8];
        addrs = '{32'h014, 32'h018, 32'h01c, 32'h011, 32'h020, 32'h024, 32'h02b, 32'h02c};
        sizes = '{size_word, size_word, size_word, size_byte,
                  size_word, size_word, size_byte, size_word};
        exps  = '{expected_word(32'h014), expected_word(32'h018), 32'hdead_beef,
                  32'h0000_00a7, expected_word(32'h020), expected_word(32'h024),
                  {24'h0, expected_byte(32'h02b)}, expected_word(32'h02c)};
        // Response k shows two falling edges after request k is driven
        for (int k = 0; k < 10; k++)
        begin
            if (k >= 2)
            begin
                check_val("rsp_valid", line_t'(rsp_valid), line_t'(1));
                check_val("rsp_data", line_t'(rsp_data), line_t'(exps[k-2]));
            end
            check_val("ready", line_t'(ready), line_t'(1));
            if (k < 8)
            begin
                req_valid    = 1'b1;
                req_addr     = addrs[k];
                req_is_store = 1'b0;
                req_size     = sizes[k];
                req_wdata    = '0;
            end
            else
                req_valid = 1'b0;
            @(negedge clock);
        end
        check_val("rsp_valid", line_t'(rsp_valid), line_t'(0));
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial
    begin
        errors = 0;
        checks = 0;
        void'($urandom(32'hf0a1_7c5c));
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_is_store = 1'b0;
        req_size     = size_byte;
        req_wdata    = '0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        check_val("rsp_valid", line_t'(rsp_valid), line_t'(0));
        check_val("addr_fault", line_t'(addr_fault), line_t'(0));
        check_val("mem_req_valid", line_t'(mem_req_valid), line_t'(0));
        check_val("ready", line_t'(ready), line_t'(0));
        rst_n = 1'b1;
        @(negedge clock);
        check_val("ready", line_t'(ready), line_t'(1));

        load_miss_then_hit();
        store_hit_readback();
        fault_access();
        evict_and_lru();
        back_to_back_hits();
        check_val("overlap_count", line_t'(overlap_count), line_t'(0));

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* verification/tb_mem_model.sv */
////////////////////////////////////////
// Line-wide memory model
// Answers fills and write-backs after a
// random delay and logs write-backs
////////////////////////////////////////
`timescale 1ns/1ps

module tb_mem_model
    import dcache_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  logic       mem_req_valid,
    input  line_addr_t mem_req_addr,
    input  logic       mem_req_is_store,
    input  line_t      mem_req_data,
    output logic       mem_rsp_valid,
    output line_t      mem_rsp_data,
    output int         wb_count,
    output line_addr_t wb_addr,
    output line_t      wb_line,
    output int         overlap_count
);

    // Lines written back so far, everything else follows the fill rule
    line_t      lines_q [line_addr_t];
    logic       busy;
    int         wait_cnt;
    line_addr_t pend_addr;
    logic       pend_store;
    line_t      pend_data;

    // Each byte mixes all four address bytes with 8'h5a
    function automatic line_t pattern_line(line_addr_t la);
        line_t result;
        addr_t a;
        for (int b = 0; b < LINE_BYTES; b++)
        begin
            a = {la, 4'(b)};
            result[b*8 +: 8] = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
        end
        return result;
    endfunction

    initial
    begin
        busy          = 1'b0;
        wait_cnt      = 0;
        pend_addr     = '0;
        pend_store    = 1'b0;
        pend_data     = '0;
        wb_count      = 0;
        wb_addr       = '0;
        wb_line       = '0;
        overlap_count = 0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        forever
        begin
            // Requests are taken at the rising edge
            @(posedge clock);
            if (rst_n && mem_req_valid)
            begin
                if (busy)
                    overlap_count++;
                pend_addr  = mem_req_addr;
                pend_store = mem_req_is_store;
                pend_data  = mem_req_data;
                wait_cnt   = $urandom_range(8, 1);
                busy       = 1'b1;
            end
            // Responses change on the falling edge
            @(negedge clock);
            mem_rsp_valid = 1'b0;
            if (busy && (wait_cnt > 0))
                wait_cnt--;
            else if (busy)
            begin
                if (pend_store)
                begin
                    lines_q[pend_addr] = pend_data;
                    wb_count++;
                    wb_addr      = pend_addr;
                    wb_line      = pend_data;
                    mem_rsp_data = '0;
                end
                else if (lines_q.exists(pend_addr))
                    mem_rsp_data = lines_q[pend_addr];
                else
                    mem_rsp_data = pattern_line(pend_addr);
                mem_rsp_valid = 1'b1;
                busy          = 1'b0;
            end
        end
    end

endmodule

/* verilog/data_cache.sv */
////////////////////////////////////////
// Write-back set-associative data cache
// Request decode, controller with LRU
// and response alignment
////////////////////////////////////////
`timescale 1ns/1ps

module data_cache
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 4,
    parameter int NUM_WAYS = 2
)
(
    input  logic       clock,
    input  logic       rst_n,

    // Core request
    input  logic       req_valid,
    input  addr_t      req_addr,
    input  logic       req_is_store,
    input  acc_size_e  req_size,
    input  word_t      req_wdata,
    output logic       ready,

    // Core response
    output logic       rsp_valid,
    output word_t      rsp_data,
    output logic       addr_fault,

    // Memory request, one line at a time
    output logic       mem_req_valid,
    output line_addr_t mem_req_addr,
    output logic       mem_req_is_store,
    output line_t      mem_req_data,

    // Memory response, fill data or write-back ack
    input  logic       mem_rsp_valid,
    input  line_t      mem_rsp_data
);

    dcache_req_if req_ch ();
    dcache_rsp_if rsp_ch ();

    // Input side
    dcache_req_decode req_decode_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_is_store (req_is_store),
        .req_size     (req_size),
        .req_wdata    (req_wdata),
        .req          (req_ch.req_decode)
    );

    // Arrays, lookup and miss handling
    dcache_ctrl #(
        .NUM_SETS         (NUM_SETS),
        .NUM_WAYS         (NUM_WAYS)
    ) ctrl_i (
        .clock            (clock),
        .rst_n            (rst_n),
        .req              (req_ch.ctrl),
        .rsp              (rsp_ch.ctrl),
        .ready            (ready),
        .mem_req_valid    (mem_req_valid),
        .mem_req_addr     (mem_req_addr),
        .mem_req_is_store (mem_req_is_store),
        .mem_req_data     (mem_req_data),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp_data     (mem_rsp_data)
    );

    // Output side
    dcache_rsp_align rsp_align_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .rsp        (rsp_ch.rsp_align),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .addr_fault (addr_fault)
    );

endmodule

/* verilog/dcache_rsp_align.sv */
////////////////////////////////////////
// Response alignment stage
// Picks the byte or word out of the line
// and registers data, valid and fault
////////////////////////////////////////
`timescale 1ns/1ps

module dcache_rsp_align
    import dcache_pkg::*;
(
    input  logic              clock,
    input  logic              rst_n,
    dcache_rsp_if.rsp_align   rsp,
    output logic              rsp_valid,
    output word_t             rsp_data,
    output logic              addr_fault
);

    line_t shifted;
    word_t aligned;

    // Move the addressed byte to bit 0, zero-extend byte loads
    always_comb
    begin
        shifted = rsp.line >> {rsp.offset, 3'b000};
        aligned = shifted[WORD_BITS-1:0];
        if (rsp.size == size_byte)
            aligned = {{(WORD_BITS - BYTE_BITS){1'b0}}, shifted[BYTE_BITS-1:0]};
    end

    // Strobes
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            rsp_valid  <= 1'b0;
            addr_fault <= 1'b0;
        end
        else
        begin
            rsp_valid  <= rsp.load_valid;
            addr_fault <= rsp.fault;
        end
    end

    // Load data, only updated on a load
    always_ff @(posedge clock)
    begin
        if (rsp.load_valid)
            rsp_data <= aligned;
    end

    // A request either faults or returns data
    assert property (@(posedge clock) disable iff (!rst_n) !(rsp_valid && addr_fault));

endmodule

/* verilog/dcache_ctrl.sv */
////////////////////////////////////////
// Cache controller
// Tag, valid, dirty and data arrays with
// hit lookup and the evict/fill FSM
////////////////////////////////////////
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 4,
    parameter int NUM_WAYS = 2
)
(
    input  logic        clock,
    input  logic        rst_n,
    dcache_req_if.ctrl  req,
    dcache_rsp_if.ctrl  rsp,
    output logic        ready,
    output logic        mem_req_valid,
    output line_addr_t  mem_req_addr,
    output logic        mem_req_is_store,
    output line_t       mem_req_data,
    input  logic        mem_rsp_valid,
    input  line_t       mem_rsp_data
);

    localparam int SET_BITS = $clog2(NUM_SETS);
    localparam int WAY_BITS = $clog2(NUM_WAYS);
    localparam int TAG_BITS = $bits(line_addr_t) - SET_BITS;

    typedef logic [SET_BITS-1:0] set_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [WAY_BITS-1:0] way_t;

    ////////////////////////////////////////
    // Arrays and control state
    ////////////////////////////////////////

    tag_t                tag_q   [NUM_SETS][NUM_WAYS];
    line_t               data_q  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_q [NUM_SETS];

    ctrl_state_e state_q;
    way_t        victim_q;
    // Fill just finished, the stage still holds the served request
    logic        done_q;
    logic        init_q;

    set_t  req_set;
    tag_t  req_tag;
    way_t  hit_way;
    way_t  lru_victim;
    logic  hit;
    logic  lookup_valid;
    logic  load_hit;
    logic  store_hit;
    logic  miss;
    logic  victim_dirty;
    logic  fill_done;
    line_t fill_line;

    // Store merge into a line, byte or aligned word
    function automatic line_t merge_store(line_t line, offset_t offset, acc_size_e size,
                                          word_t data);
        line_t merged;
        merged = line;
        if (size == size_byte)
            merged[{offset, 3'b000} +: BYTE_BITS] = data[BYTE_BITS-1:0];
        else
            merged[{offset[3:2], 5'b00000} +: WORD_BITS] = data;
        return merged;
    endfunction

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////

    assign req_set = req.addr[OFFSET_BITS +: SET_BITS];
    assign req_tag = req.addr[OFFSET_BITS + SET_BITS +: TAG_BITS];

    // Compare every way of the set
    always_comb
    begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (valid_q[req_set][w] && (tag_q[req_set][w] == req_tag))
            begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign lookup_valid = req.valid && !done_q && (state_q == idle);
    assign load_hit     = lookup_valid && !req.fault && hit && !req.is_store;
    assign store_hit    = lookup_valid && !req.fault && hit && req.is_store;
    assign miss         = lookup_valid && !req.fault && !hit;
    assign victim_dirty = dirty_q[req_set][lru_victim];
    assign fill_done    = (state_q == bring_line) && mem_rsp_valid;
    assign fill_line    = req.is_store ?
                          merge_store(mem_rsp_data, req.addr[OFFSET_BITS-1:0], req.size,
                                      req.wdata) :
                          mem_rsp_data;

    // Stage is frozen from the miss cycle until the fill lands
    assign req.stall = !init_q || (state_q != idle) || miss;
    assign ready     = !req.stall;

    ////////////////////////////////////////
    // Memory requests
    ////////////////////////////////////////

    always_comb
    begin
        mem_req_valid    = 1'b0;
        mem_req_is_store = 1'b0;
        mem_req_addr     = req.addr[ADDR_BITS-1:OFFSET_BITS];
        mem_req_data     = data_q[req_set][lru_victim];
        // Dirty victim goes out first
        if (miss && victim_dirty)
        begin
            mem_req_valid    = 1'b1;
            mem_req_is_store = 1'b1;
            mem_req_addr     = {tag_q[req_set][lru_victim], req_set};
        end
        // Fill on a clean miss or after the write-back ack
        else if (miss || ((state_q == evict_line) && mem_rsp_valid))
            mem_req_valid = 1'b1;
    end

    ////////////////////////////////////////
    // Responses
    ////////////////////////////////////////

    assign rsp.load_valid = load_hit || (fill_done && !req.is_store);
    assign rsp.fault      = lookup_valid && req.fault;
    assign rsp.line       = fill_done ? mem_rsp_data : data_q[req_set][hit_way];
    assign rsp.offset     = req.addr[OFFSET_BITS-1:0];
    assign rsp.size       = req.size;

    ////////////////////////////////////////
    // FSM, valid and dirty bits
    ////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            state_q <= idle;
            done_q  <= 1'b0;
            init_q  <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end
        else
        begin
            init_q <= 1'b1;
            done_q <= fill_done;
            case (state_q)
                idle:
                begin
                    if (miss && victim_dirty)
                    begin
                        // Line leaves the cache with the write-back
                        valid_q[req_set][lru_victim] <= 1'b0;
                        dirty_q[req_set][lru_victim] <= 1'b0;
                        state_q                      <= evict_line;
                    end
                    else if (miss)
                        state_q <= bring_line;
                    else if (store_hit)
                        dirty_q[req_set][hit_way] <= 1'b1;
                end
                evict_line:
                begin
                    if (mem_rsp_valid)
                        state_q <= bring_line;
                end
                bring_line:
                begin
                    if (mem_rsp_valid)
                    begin
                        valid_q[req_set][victim_q] <= 1'b1;
                        dirty_q[req_set][victim_q] <= req.is_store;
                        state_q                    <= idle;
                    end
                end
                default:
                    state_q <= idle;
            endcase
        end
    end

    // Data and tag arrays, victim way latch
    always_ff @(posedge clock)
    begin
        if (miss)
            victim_q <= lru_victim;
        if (store_hit)
            data_q[req_set][hit_way] <= merge_store(data_q[req_set][hit_way],
                                                    req.addr[OFFSET_BITS-1:0], req.size,
                                                    req.wdata);
        if (fill_done)
        begin
            data_q[req_set][victim_q] <= fill_line;
            tag_q[req_set][victim_q]  <= req_tag;
        end
    end

    ////////////////////////////////////////
    // Replacement
    ////////////////////////////////////////

    // Hits and fills both count as an access
    dcache_lru #(
        .NUM_SETS     (NUM_SETS),
        .NUM_WAYS     (NUM_WAYS)
    ) lru_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .access_valid (load_hit || store_hit || fill_done),
        .access_set   (req_set),
        .access_way   (fill_done ? victim_q : hit_way),
        .lookup_set   (req_set),
        .valid_ways   (valid_q[req_set]),
        .victim_way   (lru_victim)
    );

    // One outstanding memory request, so never two pulses in a row
    assert property (@(posedge clock) disable iff (!rst_n)
        mem_req_valid |=> !mem_req_valid);

    // Misaligned requests never start miss handling
    assert property (@(posedge clock) disable iff (!rst_n)
        ((state_q == idle) && req.valid && req.fault) |=> (state_q == idle));

endmodule

/* verilog/dcache_lru.sv */
////////////////////////////////////////
// Least recently used tracking
// Age counter per way and set, picks the
// victim way for a miss
////////////////////////////////////////
`timescale 1ns/1ps

module dcache_lru
#(
    parameter  int NUM_SETS = 4,
    parameter  int NUM_WAYS = 2,
    localparam int SET_BITS = $clog2(NUM_SETS),
    localparam int WAY_BITS = $clog2(NUM_WAYS)
)
(
    input  logic                clock,
    input  logic                rst_n,
    input  logic                access_valid,
    input  logic [SET_BITS-1:0] access_set,
    input  logic [WAY_BITS-1:0] access_way,
    input  logic [SET_BITS-1:0] lookup_set,
    input  logic [NUM_WAYS-1:0] valid_ways,
    output logic [WAY_BITS-1:0] victim_way
);

    // Age 0 is youngest, NUM_WAYS-1 is oldest
    logic [WAY_BITS-1:0] age_q [NUM_SETS][NUM_WAYS];

    // Accessed way becomes youngest, younger ways age by one
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                for (int w = 0; w < NUM_WAYS; w++)
                    age_q[s][w] <= WAY_BITS'(w);
            end
        end
        else if (access_valid)
        begin
            for (int w = 0; w < NUM_WAYS; w++)
            begin
                if (WAY_BITS'(w) == access_way)
                    age_q[access_set][w] <= '0;
                else if (age_q[access_set][w] < age_q[access_set][access_way])
                    age_q[access_set][w] <= age_q[access_set][w] + 1'b1;
            end
        end
    end

    // Oldest way by default, lowest invalid way wins over it
    always_comb
    begin
        victim_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--)
        begin
            if (age_q[lookup_set][w] == WAY_BITS'(NUM_WAYS - 1))
                victim_way = WAY_BITS'(w);
        end
        for (int w = NUM_WAYS - 1; w >= 0; w--)
        begin
            if (!valid_ways[w])
                victim_way = WAY_BITS'(w);
        end
    end

    // Controller must only name existing ways
    assert property (@(posedge clock) disable iff (!rst_n)
        access_valid |-> (int'(access_way) < NUM_WAYS));

endmodule

/* verilog/dcache_req_decode.sv */
////////////////////////////////////////
// Request decode stage
// Checks word alignment and registers
// the request, holding it while stalled
////////////////////////////////////////
`timescale 1ns/1ps

module dcache_req_decode
    import dcache_pkg::*;
(
    input  logic              clock,
    input  logic              rst_n,
    input  logic              req_valid,
    input  addr_t             req_addr,
    input  logic              req_is_store,
    input  acc_size_e         req_size,
    input  word_t             req_wdata,
    dcache_req_if.req_decode  req
);

    // Word access must sit on a 4-byte boundary
    logic misaligned;

    assign misaligned = (req_size == size_word) && (req_addr[1:0] != 2'b00);

    ////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////

    // Valid flag, dropped when nothing new comes in
    always_ff @(posedge clock)
    begin
        if (!rst_n)
            req.valid <= 1'b0;
        else if (!req.stall)
            req.valid <= req_valid;
    end

    // Request fields, frozen during a stall
    always_ff @(posedge clock)
    begin
        if (!req.stall && req_valid)
        begin
            req.fault    <= misaligned;
            req.is_store <= req_is_store;
            req.size     <= req_size;
            req.addr     <= req_addr;
            req.wdata    <= req_wdata;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Byte accesses can never be misaligned
    assert property (@(posedge clock) disable iff (!rst_n)
        (req.valid && req.fault) |-> (req.size == size_word));

endmodule

/* verilog/dcache_rsp_if.sv */
////////////////////////////////////////
// Response channel
// Line data and load/fault strobes from
// the controller to the output stage
////////////////////////////////////////
`timescale 1ns/1ps

interface dcache_rsp_if
    import dcache_pkg::*;
();

    logic      load_valid;
    logic      fault;
    line_t     line;
    offset_t   offset;
    acc_size_e size;

    modport ctrl      (output load_valid, fault, line, offset, size);
    modport rsp_align (input load_valid, fault, line, offset, size);

endinterface

/* verilog/dcache_req_if.sv */
////////////////////////////////////////
// Decoded request channel
// Stage register contents towards the
// controller, stall coming back
////////////////////////////////////////
`timescale 1ns/1ps

interface dcache_req_if
    import dcache_pkg::*;
();

    logic      valid;
    logic      fault;
    logic      is_store;
    acc_size_e size;
    addr_t     addr;
    word_t     wdata;

    // Controller holds the stage while a miss is serviced
    logic      stall;

    modport req_decode (output valid, fault, is_store, size, addr, wdata, input stall);
    modport ctrl       (input valid, fault, is_store, size, addr, wdata, output stall);

endinterface

/* verilog/dcache_pkg.sv */
////////////////////////////////////////
// Data cache shared definitions
// Widths, address field types and the
// encodings used by every cache block
////////////////////////////////////////

package dcache_pkg;

    ////////////////////////////////////////
    // Fixed geometry
    ////////////////////////////////////////

    // Core side
    localparam int ADDR_BITS = 32;
    localparam int WORD_BITS = 32;
    localparam int BYTE_BITS = 8;

    // Line geometry, one line is 16 bytes
    localparam int LINE_BYTES  = 16;
    localparam int LINE_BITS   = LINE_BYTES * BYTE_BITS;
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [LINE_BITS-1:0] line_t;

    // Byte position inside a line
    typedef logic [OFFSET_BITS-1:0] offset_t;

    // Address of a whole line, as seen by memory
    typedef logic [ADDR_BITS-OFFSET_BITS-1:0] line_addr_t;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Load/store width
    typedef enum logic {
        size_byte = 1'b0,
        size_word = 1'b1
    } acc_size_e;

    // Miss handling FSM
    typedef enum logic [1:0] {
        idle       = 2'd0,
        evict_line = 2'd1,
        bring_line = 2'd2
    } ctrl_state_e;

endpackage
